//--- include/gba_io_map.svh
// Word addresses of the memory-mapped I/O registers and the IF bit layout.
// Pulled in by the I/O package, which re-exports these as localparams.
`ifndef GBA_IO_MAP_SVH
`define GBA_IO_MAP_SVH

// Timer n sits at TM0 + 4n
// Low half is counter (read) or reload (write), high half is control
`define GBA_IO_ADDR_TM0   32'h0400_0100

// IE in the low half, IF read / acknowledge in the high half
`define GBA_IO_ADDR_IE    32'h0400_0200
`define GBA_IO_ADDR_IME   32'h0400_0208

// Debug LED word n at LED0 + 4n
`define GBA_IO_ADDR_LED0  32'h0400_0400

// Timers 1 to 3 take the next IF bits up
`define GBA_IRQ_TIMER0_BIT 3

`endif

//--- verilog/gba_io_pkg.sv
// Shared types and constants of the I/O block.
// Modules pull this in with a wildcard import in their body.
package gba_io_pkg;

    `include "gba_io_map.svh"

    localparam int NUM_TIMERS   = 4;
    localparam int NUM_LED_REGS = 4;

    localparam logic [31:0] IO_ADDR_TM0  = `GBA_IO_ADDR_TM0;
    localparam logic [31:0] IO_ADDR_IE   = `GBA_IO_ADDR_IE;
    localparam logic [31:0] IO_ADDR_IME  = `GBA_IO_ADDR_IME;
    localparam logic [31:0] IO_ADDR_LED0 = `GBA_IO_ADDR_LED0;

    localparam int IRQ_TIMER0_BIT = `GBA_IRQ_TIMER0_BIT;

    // Timer control byte layout
    localparam int TCTRL_PRESCALE_LSB = 0;
    localparam int TCTRL_PRESCALE_MSB = 1;
    localparam int TCTRL_CASCADE_BIT  = 2;
    localparam int TCTRL_IRQ_EN_BIT   = 6;
    localparam int TCTRL_ENABLE_BIT   = 7;

    typedef enum logic [3:0] {
        REG_TM0   = 4'd0,
        REG_TM1   = 4'd1,
        REG_TM2   = 4'd2,
        REG_TM3   = 4'd3,
        REG_IE_IF = 4'd4,
        REG_IME   = 4'd5,
        REG_LED0  = 4'd6,
        REG_LED1  = 4'd7,
        REG_LED2  = 4'd8,
        REG_LED3  = 4'd9,
        REG_NONE  = 4'd15
    } io_reg_e;

    typedef enum logic [1:0] {
        PRE_1    = 2'd0,
        PRE_64   = 2'd1,
        PRE_256  = 2'd2,
        PRE_1024 = 2'd3
    } prescale_e;

endpackage

//--- verilog/io_addr_decode.sv
// Address decoder for the CPU-side register bus.
// Maps a word address onto a register select and splits the request
// into write and read strobes. Unmapped or unaligned addresses give REG_NONE.
`timescale 1ns/1ps

module io_addr_decode (
    input  logic                bus_req,
    input  logic                bus_write,
    input  logic [31:0]         bus_addr,
    output gba_io_pkg::io_reg_e reg_sel,
    output logic                wr_en,
    output logic                rd_en
);
    import gba_io_pkg::*;

    logic [31:0] tm_off;
    logic [31:0] led_off;

    // Offsets wrap to large values below the base, so one compare suffices
    assign tm_off  = bus_addr - IO_ADDR_TM0;
    assign led_off = bus_addr - IO_ADDR_LED0;

    always_comb begin
        reg_sel = REG_NONE;
        if (bus_addr[1:0] == 2'b00) begin
            if (tm_off < 32'(4 * NUM_TIMERS)) begin
                reg_sel = io_reg_e'(REG_TM0 + {2'b00, tm_off[3:2]});
            end else if (bus_addr == IO_ADDR_IE) begin
                reg_sel = REG_IE_IF;
            end else if (bus_addr == IO_ADDR_IME) begin
                reg_sel = REG_IME;
            end else if (led_off < 32'(4 * NUM_LED_REGS)) begin
                reg_sel = io_reg_e'(REG_LED0 + {2'b00, led_off[3:2]});
            end
        end
    end

    assign wr_en = bus_req && bus_write;
    assign rd_en = bus_req && !bus_write;

endmodule

//--- verilog/gba_timer.sv
// One 16-bit timer with prescaler, cascade input and reload on overflow.
// Overflow is a one-cycle pulse, fed to the next timer and to the IRQ logic.
`timescale 1ns/1ps

module gba_timer (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        reload_wr,
    input  logic [15:0] reload_val,
    input  logic        ctrl_wr,
    input  logic [7:0]  ctrl_val,
    input  logic        cascade_in,
    output logic [15:0] count,
    output logic [7:0]  ctrl,
    output logic        overflow
);
    import gba_io_pkg::*;

    logic [15:0] reload;
    logic [9:0]  pre_cnt;
    logic        running;
    logic        start;
    logic        tick;
    prescale_e   prescale;

    assign prescale = prescale_e'(ctrl[TCTRL_PRESCALE_MSB:TCTRL_PRESCALE_LSB]);
    assign running  = ctrl[TCTRL_ENABLE_BIT];
    // Enable going from 0 to 1
    assign start    = ctrl_wr && ctrl_val[TCTRL_ENABLE_BIT] && !running;

    always_comb begin
        if (ctrl[TCTRL_CASCADE_BIT]) begin
            tick = cascade_in;
        end else begin
            case (prescale)
                PRE_1:   tick = 1'b1;
                PRE_64:  tick = &pre_cnt[5:0];
                PRE_256: tick = &pre_cnt[7:0];
                default: tick = &pre_cnt;
            endcase
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reload   <= '0;
            ctrl     <= '0;
            count    <= '0;
            pre_cnt  <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (reload_wr) begin
                reload <= reload_val;
            end
            if (ctrl_wr) begin
                ctrl <= ctrl_val;
            end
            if (start) begin
                // Reload written in the same word wins
                count   <= reload_wr ? reload_val : reload;
                pre_cnt <= '0;
            end else if (running) begin
                pre_cnt <= pre_cnt + 10'd1;
                if (tick) begin
                    if (count == 16'hFFFF) begin
                        count    <= reload;
                        overflow <= 1'b1;
                    end else begin
                        count <= count + 16'd1;
                    end
                end
            end
        end
    end

endmodule

//--- verilog/interrupt_controller.sv
// Interrupt controller holding IF.
// Timer events set IF bits, writes of one acknowledge them, and nirq
// is asserted low when IME is on and any enabled IF bit is pending.
`timescale 1ns/1ps

module interrupt_controller (
    input  logic        clock,
    input  logic        arst_n,
    input  logic [15:0] ie,
    input  logic        ime,
    input  logic [15:0] ack_mask,
    input  logic [3:0]  timer_irq,
    output logic [15:0] reg_if,
    output logic        nirq
);
    import gba_io_pkg::*;

    logic [15:0] irq_set;

    // Only the timer sources exist here, the rest stay zero
    always_comb begin
        irq_set = '0;
        irq_set[IRQ_TIMER0_BIT +: NUM_TIMERS] = timer_irq;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reg_if <= '0;
            nirq   <= 1'b1;
        end else begin
            // A new event beats an acknowledge in the same cycle
            reg_if <= (reg_if & ~ack_mask) | irq_set;
            nirq   <= !(ime && |(ie & reg_if));
        end
    end

endmodule

//--- verilog/io_regs.sv
// Register file of the I/O block.
// Holds IE, IME and the debug LED words, and hosts the four timers and the
// interrupt controller. rd_value follows reg_sel combinationally.
`timescale 1ns/1ps

module io_regs (
    input  logic                clock,
    input  logic                arst_n,
    input  gba_io_pkg::io_reg_e reg_sel,
    input  logic                wr_en,
    input  logic [31:0]         wdata,
    output logic [31:0]         rd_value,
    output logic [31:0]         led0,
    output logic [31:0]         led1,
    output logic [31:0]         led2,
    output logic [31:0]         led3,
    output logic                nirq
);
    import gba_io_pkg::*;

    logic [15:0] ie;
    logic        ime;
    logic [15:0] reg_if;
    logic [15:0] ack_mask;
    logic [31:0] led_regs [NUM_LED_REGS];
    logic [1:0]  led_idx;
    logic [1:0]  tm_idx;

    logic [15:0]           tm_count [NUM_TIMERS];
    logic [7:0]            tm_ctrl  [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] tm_wr;
    logic [NUM_TIMERS-1:0] tm_ovf;
    logic [NUM_TIMERS-1:0] cascade;
    logic [NUM_TIMERS-1:0] timer_irq;

    assign tm_idx  = 2'(reg_sel - REG_TM0);
    assign led_idx = 2'(reg_sel - REG_LED0);

    // Timer n counts on overflows of timer n-1, timer 0 has no source
    assign cascade = {tm_ovf[NUM_TIMERS-2:0], 1'b0};

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        assign tm_wr[i]     = wr_en && (reg_sel == io_reg_e'(REG_TM0 + 4'(i)));
        assign timer_irq[i] = tm_ovf[i] && tm_ctrl[i][TCTRL_IRQ_EN_BIT];

        gba_timer i_gba_timer (
            .clock      (clock),
            .arst_n     (arst_n),
            .reload_wr  (tm_wr[i]),
            .reload_val (wdata[15:0]),
            .ctrl_wr    (tm_wr[i]),
            .ctrl_val   (wdata[23:16]),
            .cascade_in (cascade[i]),
            .count      (tm_count[i]),
            .ctrl       (tm_ctrl[i]),
            .overflow   (tm_ovf[i])
        );
    end

    // High half of the IE word acknowledges IF
    assign ack_mask = (wr_en && reg_sel == REG_IE_IF) ? wdata[31:16] : 16'h0000;

    interrupt_controller i_interrupt_controller (
        .clock     (clock),
        .arst_n    (arst_n),
        .ie        (ie),
        .ime       (ime),
        .ack_mask  (ack_mask),
        .timer_irq (timer_irq),
        .reg_if    (reg_if),
        .nirq      (nirq)
    );

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ie       <= '0;
            ime      <= 1'b0;
            led_regs <= '{default: '0};
        end else if (wr_en) begin
            case (reg_sel)
                REG_IE_IF: ie <= wdata[15:0];
                REG_IME:   ime <= wdata[0];
                REG_LED0, REG_LED1, REG_LED2, REG_LED3: led_regs[led_idx] <= wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_sel)
            REG_TM0, REG_TM1, REG_TM2, REG_TM3:
                rd_value = {8'h00, tm_ctrl[tm_idx], tm_count[tm_idx]};
            REG_IE_IF: rd_value = {reg_if, ie};
            REG_IME:   rd_value = {31'd0, ime};
            REG_LED0, REG_LED1, REG_LED2, REG_LED3:
                rd_value = led_regs[led_idx];
            default:   rd_value = '0;
        endcase
    end

    assign led0 = led_regs[0];
    assign led1 = led_regs[1];
    assign led2 = led_regs[2];
    assign led3 = led_regs[3];

endmodule

//--- verilog/io_read_return.sv
// Read-data return stage.
// Captures the selected register value one cycle after a read request
// and raises bus_rvalid for that cycle. Back-to-back reads stream out.
`timescale 1ns/1ps

module io_read_return (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                rd_en,
    input  gba_io_pkg::io_reg_e reg_sel,
    input  logic [31:0]         rd_value,
    output logic [31:0]         bus_rdata,
    output logic                bus_rvalid
);
    import gba_io_pkg::*;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bus_rvalid <= 1'b0;
        end else begin
            bus_rvalid <= rd_en;
        end
    end

    // Unmapped reads return zero
    always_ff @(posedge clock) begin
        if (rd_en) begin
            bus_rdata <= (reg_sel == REG_NONE) ? 32'd0 : rd_value;
        end
    end

endmodule

//--- verilog/led_controller.sv
// Debug LED display.
// sw 0 to 15 shows one byte of the LED words, starting at the low byte
// of led0. Any other value shows a button byte, upper one if sw[7] is set.
`timescale 1ns/1ps

module led_controller (
    input  logic [7:0]  sw,
    input  logic [31:0] led0,
    input  logic [31:0] led1,
    input  logic [31:0] led2,
    input  logic [31:0] led3,
    input  logic [15:0] buttons,
    output logic [7:0]  ld
);

    logic [127:0] led_bytes;

    assign led_bytes = {led3, led2, led1, led0};

    always_comb begin
        if (sw < 8'd16) begin
            ld = led_bytes[{sw[3:0], 3'b000} +: 8];
        end else if (sw[7]) begin
            ld = buttons[15:8];
        end else begin
            ld = buttons[7:0];
        end
    end

endmodule

//--- verilog/gba_io_top.sv
// Top of the memory-mapped I/O block.
// Address decode feeds the register file, whose read value goes through
// the return stage onto the bus. LED words and pad buttons drive ld.
`timescale 1ns/1ps

module gba_io_top (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        bus_req,
    input  logic        bus_write,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_wdata,
    output logic [31:0] bus_rdata,
    output logic        bus_rvalid,
    input  logic [15:0] buttons,
    input  logic [7:0]  sw,
    output logic [7:0]  ld,
    output logic        nirq
);
    import gba_io_pkg::*;

    io_reg_e     reg_sel;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] rd_value;
    logic [31:0] led0;
    logic [31:0] led1;
    logic [31:0] led2;
    logic [31:0] led3;

    io_addr_decode i_io_addr_decode (
        .bus_req   (bus_req),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .reg_sel   (reg_sel),
        .wr_en     (wr_en),
        .rd_en     (rd_en)
    );

    io_regs i_io_regs (
        .clock    (clock),
        .arst_n   (arst_n),
        .reg_sel  (reg_sel),
        .wr_en    (wr_en),
        .wdata    (bus_wdata),
        .rd_value (rd_value),
        .led0     (led0),
        .led1     (led1),
        .led2     (led2),
        .led3     (led3),
        .nirq     (nirq)
    );

    io_read_return i_io_read_return (
        .clock      (clock),
        .arst_n     (arst_n),
        .rd_en      (rd_en),
        .reg_sel    (reg_sel),
        .rd_value   (rd_value),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid)
    );

    led_controller i_led_controller (
        .sw      (sw),
        .led0    (led0),
        .led1    (led1),
        .led2    (led2),
        .led3    (led3),
        .buttons (buttons),
        .ld      (ld)
    );

endmodule

//--- verif/tb_gba_io_top.sv
// Testbench for the memory-mapped I/O block.
// Drives the register bus through write and read tasks, keeps a shadow copy
// of the IE, IME and LED registers, and checks every returned read word.
// Also covers the LED display, timer 0 counting, cascade into timer 1 and nirq.
`timescale 1ns/1ps

module tb_gba_io_top;
    import gba_io_pkg::*;

    localparam int NUM_RW         = 64;
    localparam int NUM_LED_CHECKS = 64;
    localparam int NUM_TM_READS   = 40;
    localparam int NUM_OPS        = 2 * NUM_RW + NUM_LED_CHECKS + NUM_TM_READS + 200;
    localparam logic [31:0] IO_ADDR_TM1 = IO_ADDR_TM0 + 32'd4;

    logic        clock;
    logic        arst_n;
    logic        bus_req;
    logic        bus_write;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        bus_rvalid;
    logic [15:0] buttons;
    logic [7:0]  sw;
    logic [7:0]  ld;
    logic        nirq;

    // Shadow registers and outstanding reads
    logic [31:0] shadow_led [4];
    logic [15:0] shadow_ie;
    logic        shadow_ime;
    logic [31:0] exp_q [$];
    bit          chk_q [$];
    logic        read_pending;
    int          seed;

    gba_io_top i_gba_io_top (
        .clock      (clock),
        .arst_n     (arst_n),
        .bus_req    (bus_req),
        .bus_write  (bus_write),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .buttons    (buttons),
        .sw         (sw),
        .ld         (ld),
        .nirq       (nirq)
    );

    always #5 clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR at %0t: %s expected 0x%08h, got 0x%08h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic void update_shadow(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] led_off;
        led_off = addr - IO_ADDR_LED0;
        if (addr == IO_ADDR_IE) begin
            shadow_ie = data[15:0];
        end else if (addr == IO_ADDR_IME) begin
            shadow_ime = data[0];
        end else if (addr[1:0] == 2'b00 && led_off < 32'd16) begin
            shadow_led[led_off[3:2]] = data;
        end
    endfunction

    // Expected read word; IF stays clear until the timers run
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] led_off;
        led_off = addr - IO_ADDR_LED0;
        expected_read = 32'd0;
        if (addr == IO_ADDR_IE) begin
            expected_read = {16'h0000, shadow_ie};
        end else if (addr == IO_ADDR_IME) begin
            expected_read = {31'd0, shadow_ime};
        end else if (addr[1:0] == 2'b00 && led_off < 32'd16) begin
            expected_read = shadow_led[led_off[3:2]];
        end
    endfunction

    function automatic logic [7:0] expected_ld(input logic [7:0] sw_v, input logic [15:0] btn);
        logic [31:0] word;
        word = shadow_led[sw_v[3:2]];
        if (sw_v < 8'd16) begin
            expected_ld = word[{sw_v[1:0], 3'b000} +: 8];
        end else if (sw_v[7]) begin
            expected_ld = btn[15:8];
        end else begin
            expected_ld = btn[7:0];
        end
    endfunction

    // All bus tasks start and end 1 ns after a rising edge
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        bus_req   = 1'b1;
        bus_write = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        @(posedge clock);
        #1;
        bus_req   = 1'b0;
        bus_write = 1'b0;
        update_shadow(addr, data);
    endtask

    task automatic read_word(input logic [31:0] addr, input bit check, output logic [31:0] data);
        exp_q.push_back(expected_read(addr));
        chk_q.push_back(check);
        bus_req  = 1'b1;
        bus_addr = addr;
        @(posedge clock);
        #1;
        bus_req = 1'b0;
        data    = bus_rdata;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    task automatic wait_nirq(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (nirq !== level) begin
            if (n == max_cycles) begin
                fail_run($sformatf("nirq did not go to %0b within %0d cycles", level, n));
            end else begin
                idle_cycles(1);
                n++;
            end
        end
    endtask

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            read_pending <= 1'b0;
        end else begin
            read_pending <= bus_req && !bus_write;
        end
    end

    // Compare returned read data mid-cycle
    always @(negedge clock) begin
        logic [31:0] exp_val;
        bit          chk;
        if (arst_n) begin
            check_value("bus_rvalid", {31'd0, bus_rvalid}, {31'd0, read_pending});
            if (bus_rvalid) begin
                if (exp_q.size() == 0) begin
                    fail_run("bus_rvalid was high with no read outstanding");
                end else begin
                    exp_val = exp_q.pop_front();
                    chk     = chk_q.pop_front();
                    if (chk) begin
                        check_value("bus_rdata", bus_rdata, exp_val);
                    end
                end
            end
        end
    end

    initial begin
        repeat (NUM_OPS * 2000) @(posedge clock);
        fail_run("Watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] rd;
        logic [15:0] count;
        logic [15:0] prev;
        int          reloads;
        bit          done;
        int          n;

        clock      = 1'b0;
        arst_n     = 1'b0;
        bus_req    = 1'b0;
        bus_write  = 1'b0;
        bus_addr   = 32'd0;
        bus_wdata  = 32'd0;
        buttons    = 16'd0;
        sw         = 8'd0;
        shadow_led = '{default: 32'd0};
        shadow_ie  = 16'd0;
        shadow_ime = 1'b0;
        seed       = 32'hbfa6;
        prev       = 16'd0;
        reloads    = 0;
        repeat (4) @(posedge clock);
        #1;
        arst_n = 1'b1;
        idle_cycles(1);

        // Register writes and readbacks, including unmapped and unaligned words
        for (int i = 0; i < NUM_RW; i++) begin
            r = $random(seed);
            case (r[2:0])
                3'd4:    addr = IO_ADDR_IE;
                3'd5:    addr = IO_ADDR_IME;
                3'd6:    addr = {8'h05, r[31:8]};
                3'd7:    addr = IO_ADDR_LED0 + 32'(r[4:3]) * 4 + 32'd2;
                default: addr = IO_ADDR_LED0 + 32'(r[4:3]) * 4;
            endcase
            write_word(addr, $random(seed));
            read_word(addr, 1'b1, rd);
        end
        // Back-to-back reads
        for (int i = 0; i < NUM_LED_REGS; i++) begin
            read_word(IO_ADDR_LED0 + 32'(i) * 4, 1'b1, rd);
        end

        // LED display against the shadow words
        for (int i = 0; i < NUM_LED_CHECKS; i++) begin
            r       = $random(seed);
            sw      = (i % 2 == 0) ? {4'h0, r[3:0]} : r[7:0];
            buttons = r[31:16];
            @(negedge clock);
            check_value("ld", {24'd0, ld}, {24'd0, expected_ld(sw, buttons)});
            idle_cycles(1);
        end

        // Timer 0, prescaler 1, reads one cycle apart
        write_word(IO_ADDR_TM0, 32'h00C0_FFF0);
        for (int i = 0; i < NUM_TM_READS; i++) begin
            read_word(IO_ADDR_TM0, 1'b0, rd);
            count = rd[15:0];
            check_value("tm0_ctrl", {24'd0, rd[23:16]}, 32'h0000_00C0);
            if (i > 0) begin
                check_value("tm0_count", {16'd0, count},
                            {16'd0, (prev == 16'hFFFF) ? 16'hFFF0 : prev + 16'd1});
                if (prev == 16'hFFFF) begin
                    reloads++;
                end
            end
            prev = count;
        end
        check_value("tm0_reloads_seen", {31'd0, reloads > 0}, 32'd1);
        read_word(IO_ADDR_IE, 1'b0, rd);
        check_value("if_timer0", {31'd0, rd[16 + IRQ_TIMER0_BIT]}, 32'd1);

        // nirq follows IE, IF and IME
        write_word(IO_ADDR_IE, 32'h0000_0008);
        write_word(IO_ADDR_IME, 32'd1);
        wait_nirq(1'b0, 100);
        write_word(IO_ADDR_TM0, 32'h0000_FFF0);
        idle_cycles(3);
        write_word(IO_ADDR_IE, 32'hFFFF_0008);
        wait_nirq(1'b1, 10);
        read_word(IO_ADDR_IE, 1'b0, rd);
        check_value("if_after_ack", {16'd0, rd[31:16]}, 32'd0);

        // Timer 1 cascaded from timer 0
        write_word(IO_ADDR_TM1, 32'h00C4_FFFF);
        write_word(IO_ADDR_TM0, 32'h00C0_FFF0);
        done = 1'b0;
        n    = 0;
        while (!done) begin
            if (n == 100) begin
                fail_run("Timer 1 IF bit never set after timer 0 overflowed");
            end else begin
                read_word(IO_ADDR_IE, 1'b0, rd);
                if (rd[16 + IRQ_TIMER0_BIT + 1]) begin
                    check_value("if_timer0_before_timer1",
                                {31'd0, rd[16 + IRQ_TIMER0_BIT]}, 32'd1);
                    done = 1'b1;
                end
                n++;
            end
        end

        // IE clear keeps nirq high while IF is pending
        write_word(IO_ADDR_IE, 32'h0000_0000);
        idle_cycles(2);
        repeat (50) begin
            check_value("nirq", {31'd0, nirq}, 32'd1);
            idle_cycles(1);
        end
        read_word(IO_ADDR_IE, 1'b0, rd);
        check_value("if_pending", {31'd0, rd[31:16] != 16'd0}, 32'd1);

        idle_cycles(2);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
verilog/gba_io_pkg.sv
verilog/io_addr_decode.sv
verilog/gba_timer.sv
verilog/interrupt_controller.sv
verilog/io_regs.sv
verilog/io_read_return.sv
verilog/led_controller.sv
verilog/gba_io_top.sv
verif/tb_gba_io_top.sv

//--- Makefile
SIM := obj_dir/Vtb_gba_io_top
SRCS := sources.f $(wildcard verilog/*.sv verif/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --top-module tb_gba_io_top -f sources.f -o Vtb_gba_io_top

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
